// File: logic/cpu_pkg.sv
package cpu_pkg;

    // ============================================================
    // Widths and basic types
    // ============================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;

    // ============================================================
    // Instruction encodings
    // ============================================================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG, // Value read in decode
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    // ============================================================
    // Control and stage registers
    // ============================================================
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    reg_dest_rd; // rd is destination, else rt
        logic    is_shift;
        logic    shift_var;   // Amount from rs
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        word_t      rs_val;
        word_t      rt_val;
        word_t      imm;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
    } id_ex_t;

    typedef struct packed {
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        word_t     alu_res;
        word_t     store_data;
        reg_addr_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t dst;
        word_t     result; // Load data or ALU result
    } mem_wb_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

endpackage

// File: logic/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   y
);
    import cpu_pkg::*;

    logic [4:0] sh;

    assign sh = a[4:0]; // Shift amount rides on operand a

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLT:  y = word_t'($signed(a) < $signed(b));
            ALU_SLTU: y = word_t'(a < b);
            ALU_SLL:  y = b << sh;
            ALU_SRL:  y = b >> sh;
            ALU_SRA:  y = word_t'($signed(b) >>> sh);
            ALU_LUI:  y = {b[15:0], 16'h0000};
            default:  y = '0;
        endcase
    end

endmodule

// File: logic/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    word_t regs [1:2**REG_ADDR_W-1]; // No storage for r0

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero, same-cycle write passes straight through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (we && addr == waddr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  cpu_pkg::reg_addr_t id_rs,
    input  cpu_pkg::reg_addr_t id_rt,
    input  logic               id_is_branch,
    input  logic               redirect,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::reg_addr_t ex_dst,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::mem_wb_t   mem_wb,
    output logic               stall,
    output logic               flush,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b,
    output cpu_pkg::fwd_sel_t  br_fwd_a,
    output cpu_pkg::fwd_sel_t  br_fwd_b
);
    import cpu_pkg::*;

    logic ex_match;
    logic mem_match;

    // Decode sources written by the instructions ahead
    assign ex_match  = (ex_dst != '0) && (ex_dst == id_rs || ex_dst == id_rt);
    assign mem_match = (ex_mem.dst != '0)
                    && (ex_mem.dst == id_rs || ex_mem.dst == id_rt);

    assign stall = (id_ex.ctrl.mem_read && ex_match)                  // Load-use
                || (id_is_branch && id_ex.ctrl.reg_write && ex_match)  // Result not ready
                || (id_is_branch && ex_mem.mem_read && mem_match);     // Load in flight

    assign flush = redirect && !stall;

    // Memory stage wins over write-back, loads never forward from memory
    function automatic fwd_sel_t pick(reg_addr_t src);
        if (src == '0) begin
            return FWD_REG;
        end
        if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.dst == src) begin
            return FWD_MEM;
        end
        if (mem_wb.reg_write && mem_wb.dst == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwd_a    = pick(id_ex.rs);
        fwd_b    = pick(id_ex.rt);
        br_fwd_a = pick(id_rs);
        br_fwd_b = pick(id_rt);
    end

endmodule

// File: logic/decoder.sv
`timescale 1ns/100ps

module decoder (
    input  cpu_pkg::word_t     instr,
    input  cpu_pkg::word_t     pc_plus4,
    input  cpu_pkg::word_t     op_a,
    input  cpu_pkg::word_t     op_b,
    output cpu_pkg::ctrl_t     ctrl,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output cpu_pkg::reg_addr_t rd,
    output logic [4:0]         shamt,
    output cpu_pkg::word_t     imm,
    output logic               is_branch,
    output logic               branch_taken,
    output logic               jump_taken,
    output cpu_pkg::word_t     target
);
    import cpu_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    zero_ext;
    word_t   imm_sext;

    // Field split
    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign shamt    = instr[10:6];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm      = zero_ext ? {16'h0000, instr[15:0]} : imm_sext;

    always_comb begin
        ctrl     = '0; // Unknown encodings fall out as a no-op
        zero_ext = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write   = 1'b1;
                ctrl.reg_dest_rd = 1'b1;
                ctrl.is_shift    = (instr[5:3] == 3'b000);
                ctrl.shift_var   = instr[2];
                case (funct)
                    F_ADD, F_ADDU:  ctrl.alu_op = ALU_ADD;
                    F_SUB, F_SUBU:  ctrl.alu_op = ALU_SUB;
                    F_AND:          ctrl.alu_op = ALU_AND;
                    F_OR:           ctrl.alu_op = ALU_OR;
                    F_XOR:          ctrl.alu_op = ALU_XOR;
                    F_NOR:          ctrl.alu_op = ALU_NOR;
                    F_SLT:          ctrl.alu_op = ALU_SLT;
                    F_SLTU:         ctrl.alu_op = ALU_SLTU;
                    F_SLL, F_SLLV:  ctrl.alu_op = ALU_SLL;
                    F_SRL, F_SRLV:  ctrl.alu_op = ALU_SRL;
                    F_SRA, F_SRAV:  ctrl.alu_op = ALU_SRA;
                    default:        ctrl = '0;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                case (opcode)
                    OP_SLTI:  ctrl.alu_op = ALU_SLT;
                    OP_SLTIU: ctrl.alu_op = ALU_SLTU;
                    OP_ANDI:  ctrl.alu_op = ALU_AND;
                    OP_ORI:   ctrl.alu_op = ALU_OR;
                    OP_XORI:  ctrl.alu_op = ALU_XOR;
                    OP_LUI:   ctrl.alu_op = ALU_LUI;
                    default:  ctrl.alu_op = ALU_ADD;
                endcase
                // Logic immediates are zero-extended
                zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI)
                        || (opcode == OP_XORI);
            end
            OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD; // Base plus offset
            end
            OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
            end
            default: ; // Branches and J write nothing
        endcase
    end

    // Branch compare on forwarded operands, resolved here in decode
    assign is_branch    = (opcode == OP_BEQ) || (opcode == OP_BNE);
    assign branch_taken = ((opcode == OP_BEQ) && (op_a == op_b))
                       || ((opcode == OP_BNE) && (op_a != op_b));
    assign jump_taken   = (opcode == OP_J);

    assign target = jump_taken ? {pc_plus4[31:28], instr[25:0], 2'b00}
                               : pc_plus4 + {imm_sext[XLEN-3:0], 2'b00};

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           flush,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t instr_in,
    output cpu_pkg::word_t pc,
    output cpu_pkg::word_t if_id_pc,
    output cpu_pkg::word_t if_id_instr
);
    import cpu_pkg::*;

    word_t pc_plus4;

    assign pc_plus4 = pc + word_t'(4);

    // Program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= redirect ? redirect_pc : pc_plus4;
        end
    end

    // Fetch/decode register, holds PC+4 for the target adders
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc <= pc_plus4;
        end
        if (rst) begin
            if_id_instr <= '0; // All-zero word is SLL r0 -> no-op
        end else if (!stall) begin
            if_id_instr <= flush ? '0 : instr_in; // Squash slot behind redirect
        end
    end

endmodule

// File: logic/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
    input  logic               clk,
    input  logic               rst,
    output cpu_pkg::word_t     imem_addr,
    input  cpu_pkg::word_t     imem_rdata,
    output cpu_pkg::dmem_req_t dmem_req,
    input  cpu_pkg::word_t     dmem_rdata
);
    import cpu_pkg::*;

    // ============================================================
    // Fetch and decode
    // ============================================================
    logic      stall;
    logic      flush;
    logic      redirect;
    word_t     if_id_pc;
    word_t     if_id_instr;
    ctrl_t     dec_ctrl;
    reg_addr_t dec_rs;
    reg_addr_t dec_rt;
    reg_addr_t dec_rd;
    logic [4:0] dec_shamt;
    word_t     dec_imm;
    logic      dec_is_branch;
    logic      branch_taken;
    logic      jump_taken;
    word_t     target;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     br_op_a;
    word_t     br_op_b;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    fwd_sel_t  br_fwd_a;
    fwd_sel_t  br_fwd_b;
    id_ex_t    id_ex;
    id_ex_t    id_ex_next;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;

    assign redirect = branch_taken || jump_taken;

    fetch_stage fetch_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .redirect    (redirect),
        .redirect_pc (target),
        .instr_in    (imem_rdata),
        .pc          (imem_addr),
        .if_id_pc    (if_id_pc),
        .if_id_instr (if_id_instr)
    );

    decoder decoder_i (
        .instr        (if_id_instr),
        .pc_plus4     (if_id_pc),
        .op_a         (br_op_a),
        .op_b         (br_op_b),
        .ctrl         (dec_ctrl),
        .rs           (dec_rs),
        .rt           (dec_rt),
        .rd           (dec_rd),
        .shamt        (dec_shamt),
        .imm          (dec_imm),
        .is_branch    (dec_is_branch),
        .branch_taken (branch_taken),
        .jump_taken   (jump_taken),
        .target       (target)
    );

    regfile regfile_i (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec_rs),
        .raddr2 (dec_rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (mem_wb.reg_write),
        .waddr  (mem_wb.dst),
        .wdata  (mem_wb.result)
    );

    function automatic word_t fwd_mux(
        fwd_sel_t sel,
        word_t    reg_val,
        word_t    mem_val,
        word_t    wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Branch compare operands
    assign br_op_a = fwd_mux(br_fwd_a, rf_rdata1, ex_mem.alu_res, mem_wb.result);
    assign br_op_b = fwd_mux(br_fwd_b, rf_rdata2, ex_mem.alu_res, mem_wb.result);

    assign id_ex_next = '{
        ctrl:   dec_ctrl,
        rs_val: rf_rdata1,
        rt_val: rf_rdata2,
        imm:    dec_imm,
        rs:     dec_rs,
        rt:     dec_rt,
        rd:     dec_rd,
        shamt:  dec_shamt
    };

    always_ff @(posedge clk) begin
        id_ex <= id_ex_next;
        if (rst || stall) begin
            id_ex.ctrl <= '0; // Bubble into execute
        end
    end

    // ============================================================
    // Execute
    // ============================================================
    reg_addr_t ex_dst;
    word_t     ex_a_fwd;
    word_t     ex_b_fwd;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_y;

    hazard_unit hazard_i (
        .id_rs        (dec_rs),
        .id_rt        (dec_rt),
        .id_is_branch (dec_is_branch),
        .redirect     (redirect),
        .id_ex        (id_ex),
        .ex_dst       (ex_dst),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .stall        (stall),
        .flush        (flush),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .br_fwd_a     (br_fwd_a),
        .br_fwd_b     (br_fwd_b)
    );

    assign ex_dst   = id_ex.ctrl.reg_dest_rd ? id_ex.rd : id_ex.rt;
    assign ex_a_fwd = fwd_mux(fwd_a, id_ex.rs_val, ex_mem.alu_res, mem_wb.result);
    assign ex_b_fwd = fwd_mux(fwd_b, id_ex.rt_val, ex_mem.alu_res, mem_wb.result);

    // Shifts take the amount in a and shift rt in b
    always_comb begin
        alu_a = ex_a_fwd;
        if (id_ex.ctrl.is_shift && !id_ex.ctrl.shift_var) begin
            alu_a = word_t'(id_ex.shamt);
        end
    end
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : ex_b_fwd;

    alu alu_i (
        .op (id_ex.ctrl.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_ff @(posedge clk) begin
        ex_mem <= '{
            reg_write:  id_ex.ctrl.reg_write,
            mem_read:   id_ex.ctrl.mem_read,
            mem_write:  id_ex.ctrl.mem_write,
            alu_res:    alu_y,
            store_data: ex_b_fwd,
            dst:        ex_dst
        };
        if (rst) begin
            ex_mem.reg_write <= 1'b0;
            ex_mem.mem_read  <= 1'b0;
            ex_mem.mem_write <= 1'b0;
        end
    end

    // ============================================================
    // Memory and write-back
    // ============================================================
    word_t mem_result;

    assign dmem_req = '{
        we:    ex_mem.mem_write,
        addr:  ex_mem.alu_res,
        wdata: ex_mem.store_data
    };

    assign mem_result = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_res;

    always_ff @(posedge clk) begin
        mem_wb <= '{reg_write: ex_mem.reg_write, dst: ex_mem.dst, result: mem_result};
        if (rst) begin
            mem_wb.reg_write <= 1'b0;
        end
    end

endmodule

// File: testbench/cpu_core_properties.sv
`timescale 1ns/100ps

module cpu_core_properties (
    input logic               clk,
    input logic               rst,
    input cpu_pkg::word_t     imem_addr,
    input cpu_pkg::dmem_req_t dmem_req,
    input logic               stall
);
    import cpu_pkg::*;

    int unsigned violations = 0; // Count of failed assertions

    // Stage flags are cleared by the reset edge
    store_off_in_reset: assert property (@(posedge clk) rst |=> !dmem_req.we)
        else begin
            violations++;
            $error("store request while the core is held in reset");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (rst)
        imem_addr[1:0] == 2'b00)
        else begin
            violations++;
            $error("instruction address %h is not word aligned", imem_addr);
        end

    store_aligned: assert property (@(posedge clk) disable iff (rst)
        dmem_req.we |-> dmem_req.addr[1:0] == 2'b00)
        else begin
            violations++;
            $error("store address %h is not word aligned", dmem_req.addr);
        end

    // A stalled cycle keeps the PC where it was
    pc_held_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(imem_addr))
        else begin
            violations++;
            $error("instruction address moved during a stall");
        end

endmodule

bind cpu_core cpu_core_properties props_i (
    .clk       (clk),
    .rst       (rst),
    .imem_addr (imem_addr),
    .dmem_req  (dmem_req),
    .stall     (stall)
);

// File: testbench/tb_cpu_core.sv
`timescale 1ns/100ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int PROG_LEN   = 54;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 128;
    localparam int NUM_STORES = 8;
    localparam int MAX_CYCLES = 4 * PROG_LEN + 100;

    logic        clk;
    logic        rst;
    word_t       imem_addr;
    word_t       imem_rdata;
    dmem_req_t   dmem_req;
    word_t       dmem_rdata;
    word_t       imem [IMEM_WORDS];
    word_t       dmem [DMEM_WORDS];
    word_t       program_words [PROG_LEN];
    dmem_req_t   expected_stores [NUM_STORES];
    int unsigned cycles = 0;

    cpu_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    // ============================================================
    // Clock, memories and timeout
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign imem_rdata = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[8:2]]; // Same-cycle load data

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[8:2]] <= dmem_req.wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the expected stores did not all appear in %0d cycles", cycles);
            stop_with_failure();
        end else if (dut_i.props_i.violations != 0) begin
            $display("A bound assertion on the core failed");
            stop_with_failure();
        end
    end

    // ============================================================
    // Instruction encoding and data patterns
    // ============================================================
    function automatic word_t r_type(funct_t fn, reg_addr_t rd, reg_addr_t rs,
                                     reg_addr_t rt, logic [4:0] sa);
        return {OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(logic [25:0] word_index);
        return {OP_J, word_index};
    endfunction

    // Shift into r0, never changes state
    function automatic word_t random_nop();
        reg_addr_t  rt;
        logic [4:0] sa;
        rt = 5'($urandom);
        sa = 5'($urandom);
        case ($urandom_range(2))
            0:       return r_type(F_SLL, 5'd0, 5'd0, rt, sa);
            1:       return r_type(F_SRL, 5'd0, 5'd0, rt, sa);
            default: return r_type(F_SRA, 5'd0, 5'd0, rt, sa);
        endcase
    endfunction

    function automatic word_t fill_word(int unsigned idx);
        return {idx[15:0] ^ 16'hC0DE, ~idx[15:0]};
    endfunction

    // ============================================================
    // Program and expected stores
    // ============================================================
    task automatic load_program();
        program_words = '{
            i_type(OP_ADDI, 5'd1, 5'd0, 16'h0100),     // r1 = store base
            i_type(OP_ADDI, 5'd2, 5'd0, 16'hFFFB),     // r2 = -5
            i_type(OP_ORI, 5'd3, 5'd0, 16'h8001),
            r_type(F_ADD, 5'd4, 5'd2, 5'd3, 5'd0),     // Forward from both stages
            i_type(OP_SW, 5'd4, 5'd1, 16'h0000),
            r_type(F_SUB, 5'd5, 5'd3, 5'd2, 5'd0),
            r_type(F_SLL, 5'd5, 5'd0, 5'd5, 5'd4),
            r_type(F_SRA, 5'd6, 5'd0, 5'd2, 5'd1),
            r_type(F_XOR, 5'd5, 5'd5, 5'd6, 5'd0),
            i_type(OP_SW, 5'd5, 5'd1, 16'h0004),
            r_type(F_SLT, 5'd7, 5'd2, 5'd3, 5'd0),     // 10
            r_type(F_SLTU, 5'd8, 5'd2, 5'd3, 5'd0),
            i_type(OP_SLTIU, 5'd9, 5'd3, 16'hFFFF),
            i_type(OP_SLTI, 5'd10, 5'd2, 16'hFFFC),
            r_type(F_SLL, 5'd9, 5'd0, 5'd9, 5'd4),
            r_type(F_SLL, 5'd8, 5'd0, 5'd8, 5'd1),     // Each compare in its own bit
            r_type(F_SLLV, 5'd10, 5'd9, 5'd10, 5'd0),
            r_type(F_OR, 5'd7, 5'd7, 5'd9, 5'd0),
            r_type(F_NOR, 5'd8, 5'd8, 5'd10, 5'd0),
            r_type(F_XOR, 5'd7, 5'd7, 5'd8, 5'd0),
            i_type(OP_SW, 5'd7, 5'd1, 16'h0008),       // 20
            i_type(OP_LUI, 5'd11, 5'd0, 16'h1234),
            i_type(OP_ORI, 5'd11, 5'd11, 16'hF0F0),
            i_type(OP_ANDI, 5'd12, 5'd11, 16'hFF00),
            i_type(OP_XORI, 5'd12, 5'd12, 16'h0FFF),
            r_type(F_SRLV, 5'd13, 5'd9, 5'd11, 5'd0),
            r_type(F_SRAV, 5'd14, 5'd9, 5'd5, 5'd0),
            r_type(F_SUBU, 5'd13, 5'd13, 5'd12, 5'd0),
            r_type(F_ADDU, 5'd13, 5'd13, 5'd14, 5'd0),
            r_type(F_SRL, 5'd15, 5'd0, 5'd13, 5'd8),
            i_type(OP_SW, 5'd15, 5'd1, 16'h000C),      // 30
            i_type(OP_LW, 5'd16, 5'd0, 16'h0008),      // Load-use pair
            r_type(F_ADD, 5'd17, 5'd16, 5'd1, 5'd0),
            i_type(OP_SW, 5'd17, 5'd1, 16'h0010),
            i_type(OP_ADDI, 5'd18, 5'd0, 16'h0007),
            i_type(OP_ADDI, 5'd19, 5'd0, 16'h0007),
            i_type(OP_BEQ, 5'd18, 5'd19, 16'h0002),    // Taken
            i_type(OP_SW, 5'd1, 5'd1, 16'h0040),
            i_type(OP_SW, 5'd1, 5'd1, 16'h0044),
            i_type(OP_BNE, 5'd19, 5'd18, 16'h0001),    // Not taken
            i_type(OP_SW, 5'd19, 5'd1, 16'h0014),      // 40
            i_type(OP_LW, 5'd20, 5'd0, 16'h000C),
            i_type(OP_BNE, 5'd18, 5'd20, 16'h0002),    // Taken on load
            i_type(OP_SW, 5'd20, 5'd1, 16'h0048),
            i_type(OP_SW, 5'd20, 5'd1, 16'h004C),
            i_type(OP_LW, 5'd21, 5'd0, 16'h0010),
            i_type(OP_BEQ, 5'd20, 5'd21, 16'h0001),    // Not taken on load
            i_type(OP_SW, 5'd21, 5'd1, 16'h0018),
            j_type(26'd51),
            i_type(OP_SW, 5'd1, 5'd1, 16'h0050),
            i_type(OP_SW, 5'd1, 5'd1, 16'h0054),       // 50
            i_type(OP_ADDI, 5'd0, 5'd0, 16'h0055),     // Write to r0
            i_type(OP_SW, 5'd0, 5'd1, 16'h001C),
            j_type(26'd53)                             // Park here
        };
    endtask

    task automatic load_expected();
        expected_stores = '{
            '{we: 1'b1, addr: 32'h0000_0100, wdata: 32'h0000_7FFC},
            '{we: 1'b1, addr: 32'h0000_0104, wdata: 32'hFFF7_FF9D},
            '{we: 1'b1, addr: 32'h0000_0108, wdata: 32'hFFFE_FFEE},
            '{we: 1'b1, addr: 32'h0000_010C, wdata: 32'h00FF_FF12},
            '{we: 1'b1, addr: 32'h0000_0110, wdata: fill_word(2) + 32'h0000_0100},
            '{we: 1'b1, addr: 32'h0000_0114, wdata: 32'h0000_0007},
            '{we: 1'b1, addr: 32'h0000_0118, wdata: fill_word(4)},
            '{we: 1'b1, addr: 32'h0000_011C, wdata: 32'h0000_0000}
        };
    endtask

    // ============================================================
    // Checks
    // ============================================================
    task automatic stop_with_failure();
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_store(dmem_req_t got, dmem_req_t exp, int idx);
        if (got !== exp) begin
            $display("Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, idx, got.wdata, got.addr, exp.wdata, exp.addr);
            stop_with_failure();
        end
    endtask

    initial begin
        void'($urandom(6));
        rst = 1'b1;
        load_program();
        load_expected();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            if (i < PROG_LEN) begin
                imem[i] = program_words[i];
            end else begin
                imem[i] = random_nop();
            end
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= fill_word(i);
        end

        // Four reset edges, then one more cycle still at the reset PC
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_word(imem_addr, RESET_PC, "imem_addr");
        end

        for (int s = 0; s < NUM_STORES; s++) begin
            do begin
                @(negedge clk);
            end while (!dmem_req.we);
            check_store(dmem_req, expected_stores[s], s);
        end

        // Parked on the final jump, nothing else may store
        repeat (20) begin
            @(negedge clk);
            if (dmem_req.we) begin
                $display("Unexpected store to %h after the last expected store", dmem_req.addr);
                stop_with_failure();
            end
        end

        if (dut_i.props_i.violations != 0) begin
            $display("Bound assertions failed %0d times", dut_i.props_i.violations);
            stop_with_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: compile.f
logic/cpu_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/hazard_unit.sv
logic/decoder.sv
logic/fetch_stage.sv
logic/cpu_core.sv
testbench/cpu_core_properties.sv
testbench/tb_cpu_core.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_cpu_core -f compile.f -Mdir obj_dir
	./obj_dir/Vtb_cpu_core | tee /dev/stderr | grep -x '\*\* PASS \*\*' > /dev/null

clean:
	rm -rf obj_dir
